//--- include/umode_params.svh
//--------------------------------------------------------------------------
// Architectural constants for the user-mode privilege monitor: widths,
// mstatus and misa bit positions, SYSTEM encodings, exception causes and
// the number of monitor checks. Include wherever one of these is needed.
//--------------------------------------------------------------------------

`ifndef UMODE_PARAMS_SVH
`define UMODE_PARAMS_SVH

// register and instruction width
`define XLEN 32

// mstatus fields
`define MSTATUS_SPP_POS  8
`define MSTATUS_MPP_POS  11
`define MSTATUS_FS_POS   13
`define MSTATUS_XS_POS   15
`define MSTATUS_MPRV_POS 17
`define MSTATUS_TW_POS   21
`define MSTATUS_SD_POS   31

// misa extension letters
`define MISA_N_POS 13
`define MISA_S_POS 18
`define MISA_U_POS 20

// exact SYSTEM encodings
`define INSN_MRET  32'h3020_0073
`define INSN_WFI   32'h1050_0073
`define INSN_URET  32'h0020_0073
`define INSN_ECALL 32'h0000_0073

// custom system instructions, matched under the mask
`define INSN_CUSTOM0     32'h8C00_0073
`define INSN_CUSTOM1     32'hCC00_0073
`define INSN_CUSTOM_MASK 32'hFC00_707F

`define OPCODE_SYSTEM 7'b111_0011

// funct3 of SYSTEM that is not a CSR access
`define SYSTEM_FUNCT3_NONCSR 3'b100

// lowest bit of the privilege field in the CSR address
`define CSR_PRIV_POS 28

`define CAUSE_ILLEGAL 6'd2
`define CAUSE_ECALL_U 6'd8

// causes that outrank illegal instruction
`define CAUSE_HIPRI_A 6'd1
`define CAUSE_HIPRI_B 6'd24
`define CAUSE_HIPRI_C 6'd25

`define CHECK_COUNT 13

`endif

//--- hdl/priv_pkg.sv
//--------------------------------------------------------------------------
// Privilege architecture types shared by the decoder, the checkers and
// the testbench: privilege mode, retired instruction class and the
// exception cause field.
//--------------------------------------------------------------------------

`default_nettype none

package priv_pkg;

  // only U and M are implemented
  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_M = 2'b11
  } priv_mode_e;

  // what the decoder made of a retired instruction
  typedef enum logic [2:0] {
    CLASS_OTHER  = 3'd0,
    CLASS_MRET   = 3'd1,
    CLASS_WFI    = 3'd2,
    CLASS_ECALL  = 3'd3,
    CLASS_URET   = 3'd4,
    CLASS_CUSTOM = 3'd5,
    CLASS_CSR    = 3'd6
  } insn_class_e;

  // low bits of mcause for synchronous exceptions
  typedef logic [5:0] exc_cause_t;

endpackage

`default_nettype wire

//--- hdl/check_pkg.sv
//--------------------------------------------------------------------------
// Monitor types: the bit position of every check and the vector that
// carries one fail flag per check.
//--------------------------------------------------------------------------

`default_nettype none

`include "umode_params.svh"

package check_pkg;

  typedef enum int unsigned {
    CHK_MISA         = 0,
    CHK_MODE         = 1,
    CHK_RESET_MODE   = 2,
    CHK_MPP          = 3,
    CHK_SPP          = 4,
    CHK_EXT_BITS     = 5,
    CHK_UMODE_MPRV   = 6,
    CHK_WFI          = 7,
    CHK_ECALL        = 8,
    CHK_ILLEGAL_INSN = 9,
    CHK_TRAP_TO_M    = 10,
    CHK_MRET_MPP     = 11,
    CHK_MRET_MPRV    = 12
  } check_id_e;

  // a set bit marks a violated check
  typedef logic [`CHECK_COUNT-1:0] check_vec_t;

endpackage

`default_nettype wire

//--- hdl/retire_decoder.sv
//--------------------------------------------------------------------------
// Classifies the retired instruction for the checkers and merges the
// mstatus write over the read value. Purely combinational; the class is
// forced to other while no retirement is presented.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "umode_params.svh"

module retire_decoder (
  input  logic [`XLEN-1:0]      rvfi_insn,
  input  logic                  rvfi_valid,
  input  logic                  trap,
  input  priv_pkg::exc_cause_t  exc_cause,
  input  logic [`XLEN-1:0]      mstatus_rdata,
  input  logic [`XLEN-1:0]      mstatus_wdata,
  input  logic [`XLEN-1:0]      mstatus_wmask,
  output priv_pkg::insn_class_e insn_class,
  output logic [1:0]            csr_addr_priv,
  output logic                  higher_prio,
  output logic [`XLEN-1:0]      mstatus_post
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_custom;
  logic       is_csr;

  assign opcode = rvfi_insn[6:0];
  assign funct3 = rvfi_insn[14:12];

  assign is_custom = ((rvfi_insn & `INSN_CUSTOM_MASK) == `INSN_CUSTOM0) ||
                     ((rvfi_insn & `INSN_CUSTOM_MASK) == `INSN_CUSTOM1);

  // csrrw/s/c and their immediate forms
  assign is_csr = (opcode == `OPCODE_SYSTEM) &&
                  (funct3 != 3'b000) &&
                  (funct3 != `SYSTEM_FUNCT3_NONCSR);

  always_comb begin
    if (!rvfi_valid) begin
      insn_class = priv_pkg::CLASS_OTHER;
    end else if (rvfi_insn == `INSN_MRET) begin
      insn_class = priv_pkg::CLASS_MRET;
    end else if (rvfi_insn == `INSN_WFI) begin
      insn_class = priv_pkg::CLASS_WFI;
    end else if (rvfi_insn == `INSN_ECALL) begin
      insn_class = priv_pkg::CLASS_ECALL;
    end else if (rvfi_insn == `INSN_URET) begin
      insn_class = priv_pkg::CLASS_URET;
    end else if (is_custom) begin
      insn_class = priv_pkg::CLASS_CUSTOM;
    end else if (is_csr) begin
      insn_class = priv_pkg::CLASS_CSR;
    end else begin
      insn_class = priv_pkg::CLASS_OTHER;
    end
  end

  // lowest privilege allowed to touch the addressed CSR
  assign csr_addr_priv = rvfi_insn[`CSR_PRIV_POS +: 2];

  // the cause field only means something on a trap
  assign higher_prio = trap &&
                       (exc_cause inside {`CAUSE_HIPRI_A, `CAUSE_HIPRI_B, `CAUSE_HIPRI_C});

  assign mstatus_post = (mstatus_wdata & mstatus_wmask) |
                        (mstatus_rdata & ~mstatus_wmask);

endmodule

`default_nettype wire

//--- hdl/csr_state_checks.sv
//--------------------------------------------------------------------------
// Static legality of misa, the retirement mode and the mstatus fields.
// Evaluated combinationally on every valid retirement.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "umode_params.svh"

module csr_state_checks (
  input  logic                 rvfi_valid,
  input  priv_pkg::priv_mode_e rvfi_mode,
  input  logic [`XLEN-1:0]     misa_rdata,
  input  logic [`XLEN-1:0]     mstatus_rdata,
  input  logic [`XLEN-1:0]     mstatus_post,
  output check_pkg::check_vec_t fails
);

  logic [1:0] mpp_post;

  assign mpp_post = mstatus_post[`MSTATUS_MPP_POS +: 2];

  always_comb begin
    fails = '0;
    if (rvfi_valid) begin
      // U present, no S and no N
      fails[check_pkg::CHK_MISA] = !misa_rdata[`MISA_U_POS] ||
                                   misa_rdata[`MISA_S_POS] ||
                                   misa_rdata[`MISA_N_POS];

      fails[check_pkg::CHK_MODE] =
        !(rvfi_mode inside {priv_pkg::MODE_U, priv_pkg::MODE_M});

      fails[check_pkg::CHK_MPP] =
        !(mpp_post inside {priv_pkg::MODE_U, priv_pkg::MODE_M});

      // no supervisor mode so SPP is hardwired
      fails[check_pkg::CHK_SPP] = mstatus_rdata[`MSTATUS_SPP_POS];

      fails[check_pkg::CHK_EXT_BITS] = (|mstatus_rdata[`MSTATUS_XS_POS +: 2]) ||
                                       (|mstatus_rdata[`MSTATUS_FS_POS +: 2]) ||
                                       mstatus_rdata[`MSTATUS_SD_POS];

      fails[check_pkg::CHK_UMODE_MPRV] = (rvfi_mode == priv_pkg::MODE_U) &&
                                         mstatus_rdata[`MSTATUS_MPRV_POS];
    end
  end

endmodule

`default_nettype wire

//--- hdl/insn_legality_checks.sv
//--------------------------------------------------------------------------
// Checks that WFI, ECALL and the instructions not allowed in U mode
// retire with the expected exception. Zero latency; the decoder class is
// already other when nothing retires.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "umode_params.svh"

module insn_legality_checks (
  input  priv_pkg::insn_class_e insn_class,
  input  priv_pkg::priv_mode_e  rvfi_mode,
  input  logic [1:0]            csr_addr_priv,
  input  logic                  trap,
  input  logic                  illegal,
  input  logic                  higher_prio,
  input  priv_pkg::exc_cause_t  exc_cause,
  input  logic [`XLEN-1:0]      mstatus_rdata,
  output check_pkg::check_vec_t fails
);

  logic in_umode;
  logic wfi_u;
  logic ecall_u;
  logic must_be_illegal;
  logic ecall_cause_ok;
  logic illegal_ok;

  assign in_umode = (rvfi_mode == priv_pkg::MODE_U);
  assign wfi_u    = (insn_class == priv_pkg::CLASS_WFI) && in_umode;
  assign ecall_u  = (insn_class == priv_pkg::CLASS_ECALL) && in_umode;

  // exactly one of illegal or an outranking cause
  assign illegal_ok = illegal ^ higher_prio;

  assign must_be_illegal =
    ((insn_class == priv_pkg::CLASS_MRET) && in_umode) ||
    (insn_class == priv_pkg::CLASS_URET) ||
    (insn_class == priv_pkg::CLASS_CUSTOM) ||
    ((insn_class == priv_pkg::CLASS_CSR) && in_umode &&
     (csr_addr_priv != priv_pkg::MODE_U));

  // the ecall cause itself or one that outranks it
  assign ecall_cause_ok = (exc_cause == `CAUSE_ECALL_U) ||
                          higher_prio;

  always_comb begin
    fails = '0;
    if (wfi_u) begin
      if (mstatus_rdata[`MSTATUS_TW_POS]) begin
        fails[check_pkg::CHK_WFI] = !illegal_ok;
      end else begin
        fails[check_pkg::CHK_WFI] = illegal;
      end
    end
    fails[check_pkg::CHK_ECALL]        = ecall_u && !(trap && ecall_cause_ok);
    fails[check_pkg::CHK_ILLEGAL_INSN] = must_be_illegal && !illegal_ok;
  end

endmodule

`default_nettype wire

//--- hdl/mode_flow_checks.sv
//--------------------------------------------------------------------------
// Mode transitions between consecutive retirements. History is taken at
// each valid retirement and held across idle cycles, so the next valid
// retirement is always compared with the one before it.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "umode_params.svh"

module mode_flow_checks (
  input  logic                  clk_i,
  input  logic                  arst_n,
  input  logic                  rvfi_valid,
  input  priv_pkg::priv_mode_e  rvfi_mode,
  input  priv_pkg::insn_class_e insn_class,
  input  logic                  trap,
  input  logic [`XLEN-1:0]      mstatus_rdata,
  input  logic [`XLEN-1:0]      mstatus_post,
  output check_pkg::check_vec_t fails
);

  logic                 seen_q;
  logic                 trap_q;
  logic                 mret_q;
  priv_pkg::priv_mode_e mpp_q;

  logic                 is_mret;
  logic                 mret_m;
  priv_pkg::priv_mode_e mpp_rd;

  assign is_mret = (insn_class == priv_pkg::CLASS_MRET) && !trap;
  assign mret_m  = is_mret && (rvfi_mode == priv_pkg::MODE_M);
  assign mpp_rd  = priv_pkg::priv_mode_e'(mstatus_rdata[`MSTATUS_MPP_POS +: 2]);

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      seen_q <= 1'b0;
      trap_q <= 1'b0;
      mret_q <= 1'b0;
    end else if (rvfi_valid) begin
      seen_q <= 1'b1;
      trap_q <= trap;
      mret_q <= mret_m;
    end
  end

  // MPP read by the last retirement
  always_ff @(posedge clk_i) begin
    if (rvfi_valid) begin
      mpp_q <= mpp_rd;
    end
  end

  always_comb begin
    fails = '0;
    if (rvfi_valid) begin
      fails[check_pkg::CHK_RESET_MODE] = !seen_q && (rvfi_mode != priv_pkg::MODE_M);

      // trap handler runs in M
      fails[check_pkg::CHK_TRAP_TO_M] = trap_q && (rvfi_mode != priv_pkg::MODE_M);

      fails[check_pkg::CHK_MRET_MPP] = mret_q && (rvfi_mode != mpp_q);

      fails[check_pkg::CHK_MRET_MPRV] = is_mret &&
                                        (mpp_rd == priv_pkg::MODE_U) &&
                                        mstatus_post[`MSTATUS_MPRV_POS];
    end
  end

endmodule

`default_nettype wire

//--- hdl/umode_monitor.sv
//--------------------------------------------------------------------------
// User-mode privilege monitor top. Takes one retirement per cycle from
// the trace, runs all checks and reports failures one cycle later as a
// single-cycle pulse with the failed bits, plus a sticky accumulation.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "umode_params.svh"

module umode_monitor (
  input  logic                  clk_i,
  input  logic                  arst_n,
  input  logic                  rvfi_valid,
  input  priv_pkg::priv_mode_e  rvfi_mode,
  input  logic [`XLEN-1:0]      rvfi_insn,
  input  logic                  trap,
  input  priv_pkg::exc_cause_t  exc_cause,
  input  logic                  illegal,
  input  logic [`XLEN-1:0]      mstatus_rdata,
  input  logic [`XLEN-1:0]      mstatus_wdata,
  input  logic [`XLEN-1:0]      mstatus_wmask,
  input  logic [`XLEN-1:0]      misa_rdata,
  output logic                  violation_valid,
  output check_pkg::check_vec_t violations,
  output check_pkg::check_vec_t error_sticky
);

  priv_pkg::insn_class_e insn_class;
  logic [1:0]            csr_addr_priv;
  logic                  higher_prio;
  logic [`XLEN-1:0]      mstatus_post;

  check_pkg::check_vec_t state_fails;
  check_pkg::check_vec_t insn_fails;
  check_pkg::check_vec_t flow_fails;
  check_pkg::check_vec_t all_fails;

  retire_decoder retire_decoder_inst (
    .rvfi_insn     (rvfi_insn),
    .rvfi_valid    (rvfi_valid),
    .trap          (trap),
    .exc_cause     (exc_cause),
    .mstatus_rdata (mstatus_rdata),
    .mstatus_wdata (mstatus_wdata),
    .mstatus_wmask (mstatus_wmask),
    .insn_class    (insn_class),
    .csr_addr_priv (csr_addr_priv),
    .higher_prio   (higher_prio),
    .mstatus_post  (mstatus_post)
  );

  csr_state_checks csr_state_checks_inst (
    .rvfi_valid    (rvfi_valid),
    .rvfi_mode     (rvfi_mode),
    .misa_rdata    (misa_rdata),
    .mstatus_rdata (mstatus_rdata),
    .mstatus_post  (mstatus_post),
    .fails         (state_fails)
  );

  insn_legality_checks insn_legality_checks_inst (
    .insn_class    (insn_class),
    .rvfi_mode     (rvfi_mode),
    .csr_addr_priv (csr_addr_priv),
    .trap          (trap),
    .illegal       (illegal),
    .higher_prio   (higher_prio),
    .exc_cause     (exc_cause),
    .mstatus_rdata (mstatus_rdata),
    .fails         (insn_fails)
  );

  mode_flow_checks mode_flow_checks_inst (
    .clk_i         (clk_i),
    .arst_n        (arst_n),
    .rvfi_valid    (rvfi_valid),
    .rvfi_mode     (rvfi_mode),
    .insn_class    (insn_class),
    .trap          (trap),
    .mstatus_rdata (mstatus_rdata),
    .mstatus_post  (mstatus_post),
    .fails         (flow_fails)
  );

  // checkers own disjoint bits
  assign all_fails = state_fails | insn_fails | flow_fails;

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      violation_valid <= 1'b0;
      violations      <= '0;
      error_sticky    <= '0;
    end else begin
      violation_valid <= |all_fails;
      violations      <= all_fails;
      error_sticky    <= error_sticky | all_fails;
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
//--------------------------------------------------------------------------
// Testbench clock and reset: a 4 ns clock and an active-low reset held
// for the first 10 rising edges.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_i,
  output logic arst_n
);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk_i);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/umode_monitor_props.sv
//--------------------------------------------------------------------------
// Output protocol properties of the monitor top, bound into every
// umode_monitor instance.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module umode_monitor_props (
  input logic                  clk_i,
  input logic                  arst_n,
  input logic                  rvfi_valid,
  input logic                  violation_valid,
  input check_pkg::check_vec_t violations,
  input check_pkg::check_vec_t error_sticky
);

  // vector only carries bits alongside the pulse
  quiet_without_pulse: assert property (@(posedge clk_i) disable iff (!arst_n)
    !violation_valid |-> (violations == '0))
    else $error("violations nonzero while violation_valid is low");

  no_pulse_after_idle: assert property (@(posedge clk_i) disable iff (!arst_n)
    !rvfi_valid |=> !violation_valid)
    else $error("violation_valid raised for a cycle without a retirement");

  sticky_keeps_bits: assert property (@(posedge clk_i) disable iff (!arst_n)
    (error_sticky & $past(error_sticky)) == $past(error_sticky))
    else $error("error_sticky dropped a bit");

endmodule

bind umode_monitor umode_monitor_props umode_monitor_props_inst (
  .clk_i           (clk_i),
  .arst_n          (arst_n),
  .rvfi_valid      (rvfi_valid),
  .violation_valid (violation_valid),
  .violations      (violations),
  .error_sticky    (error_sticky)
);

`default_nettype wire

//--- bench/umode_monitor_tb.sv
//--------------------------------------------------------------------------
// Directed testbench for the user-mode privilege monitor. Each test task
// drives retirements and compares the registered violation outputs with
// vectors built from the check rules.
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "umode_params.svh"

module umode_monitor_tb;

  localparam int          RESET_TIMEOUT  = 40;
  localparam int          RESULT_TIMEOUT = 4;
  localparam logic [31:0] MISA_OK        = 32'h4010_0100;
  localparam logic [31:0] NOP            = 32'h0000_0013;
  // csrrs x1, mstatus, x0 and csrrw x0, mstatus, x1
  localparam logic [31:0] CSRRS_MSTATUS  = 32'h3000_20F3;
  localparam logic [31:0] CSRRW_MSTATUS  = 32'h3000_9073;

  logic                  clk_i;
  logic                  arst_n;
  logic                  rvfi_valid;
  priv_pkg::priv_mode_e  rvfi_mode;
  logic [31:0]           rvfi_insn;
  logic                  trap;
  priv_pkg::exc_cause_t  exc_cause;
  logic                  illegal;
  logic [31:0]           mstatus_rdata;
  logic [31:0]           mstatus_wdata;
  logic [31:0]           mstatus_wmask;
  logic [31:0]           misa_rdata;
  logic                  violation_valid;
  check_pkg::check_vec_t violations;
  check_pkg::check_vec_t error_sticky;

  // next retirement to drive
  logic [1:0]            r_mode;
  logic [31:0]           r_insn;
  logic                  r_trap;
  logic [5:0]            r_cause;
  logic                  r_ill;
  logic [31:0]           r_ms_rd;
  logic [31:0]           r_ms_wd;
  logic [31:0]           r_ms_wm;
  logic [31:0]           r_misa;
  check_pkg::check_vec_t sticky_exp;
  int unsigned           edge_cnt = 0;

  tb_clock tb_clock_inst (
    .clk_i  (clk_i),
    .arst_n (arst_n)
  );

  umode_monitor umode_monitor_inst (
    .clk_i           (clk_i),
    .arst_n          (arst_n),
    .rvfi_valid      (rvfi_valid),
    .rvfi_mode       (rvfi_mode),
    .rvfi_insn       (rvfi_insn),
    .trap            (trap),
    .exc_cause       (exc_cause),
    .illegal         (illegal),
    .mstatus_rdata   (mstatus_rdata),
    .mstatus_wdata   (mstatus_wdata),
    .mstatus_wmask   (mstatus_wmask),
    .misa_rdata      (misa_rdata),
    .violation_valid (violation_valid),
    .violations      (violations),
    .error_sticky    (error_sticky)
  );

  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  function automatic check_pkg::check_vec_t bit_for(input check_pkg::check_id_e id);
    return check_pkg::check_vec_t'(1) << id;
  endfunction

  task automatic stop_failed();
    $display("Some tests failed");
    $fatal(1, "monitor testbench stopped at the first error");
  endtask

  // clean retirement, tests override single fields afterwards
  task automatic prep(input logic [1:0] mode, input logic [31:0] insn);
    r_mode  = mode;
    r_insn  = insn;
    r_trap  = 1'b0;
    r_cause = '0;
    r_ill   = 1'b0;
    r_ms_rd = '0;
    r_ms_wd = '0;
    r_ms_wm = '0;
    r_misa  = MISA_OK;
  endtask

  task automatic with_trap(input logic [5:0] cause);
    r_trap  = 1'b1;
    r_cause = cause;
    r_ill   = (cause == `CAUSE_ILLEGAL);
  endtask

  // called at a falling edge, returns at the falling edge after the result
  task automatic retire(input string name, input check_pkg::check_vec_t exp);
    int unsigned start;
    int          waited;
    start  = edge_cnt;
    waited = 0;
    @(posedge clk_i);
    rvfi_valid    <= 1'b1;
    rvfi_mode     <= priv_pkg::priv_mode_e'(r_mode);
    rvfi_insn     <= r_insn;
    trap          <= r_trap;
    exc_cause     <= r_cause;
    illegal       <= r_ill;
    mstatus_rdata <= r_ms_rd;
    mstatus_wdata <= r_ms_wd;
    mstatus_wmask <= r_ms_wm;
    misa_rdata    <= r_misa;
    @(posedge clk_i);
    rvfi_valid <= 1'b0;
    while (edge_cnt < start + 2) begin
      if (waited == RESULT_TIMEOUT) begin
        $display("%s: no result edge within %0d cycles", name, waited);
        stop_failed();
      end
      @(negedge clk_i);
      waited++;
    end
    sticky_exp = sticky_exp | exp;
    assert (violations === exp) else begin
      $display("[ERROR] %s: violations expected %h, actual %h", name, exp, violations);
      stop_failed();
    end
    assert (violation_valid === (|exp)) else begin
      $display("[ERROR] %s: violation_valid expected %b, actual %b",
               name, |exp, violation_valid);
      stop_failed();
    end
    assert (error_sticky === sticky_exp) else begin
      $display("[ERROR] %s: error_sticky expected %h, actual %h",
               name, sticky_exp, error_sticky);
      stop_failed();
    end
  endtask

  // trap handler retirement in M after every trapping one
  task automatic handle_trap(input string name);
    prep(priv_pkg::MODE_M, NOP);
    retire({name, "_handler"}, '0);
  endtask

  task automatic idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
    end
  endtask

  task automatic test_reset_and_legal();
    prep(priv_pkg::MODE_U, NOP);
    retire("reset_first_u", bit_for(check_pkg::CHK_RESET_MODE));
    prep(priv_pkg::MODE_M, NOP);
    retire("reset_legal_m", '0);
    prep(priv_pkg::MODE_U, NOP);
    retire("reset_legal_u", '0);
  endtask

  task automatic test_csr_state();
    prep(priv_pkg::MODE_M, NOP);
    r_misa = MISA_OK | (32'h1 << `MISA_S_POS);
    retire("csr_misa_s", bit_for(check_pkg::CHK_MISA));
    prep(2'd2, NOP);
    retire("csr_mode_2", bit_for(check_pkg::CHK_MODE));
    prep(priv_pkg::MODE_M, CSRRW_MSTATUS);
    r_ms_wd = 32'h2 << `MSTATUS_MPP_POS;
    r_ms_wm = 32'h3 << `MSTATUS_MPP_POS;
    retire("csr_mpp_2", bit_for(check_pkg::CHK_MPP));
    prep(priv_pkg::MODE_M, NOP);
    r_ms_rd = 32'h1 << `MSTATUS_SPP_POS;
    retire("csr_spp", bit_for(check_pkg::CHK_SPP));
    prep(priv_pkg::MODE_M, NOP);
    r_ms_rd = 32'h1 << `MSTATUS_FS_POS;
    retire("csr_fs", bit_for(check_pkg::CHK_EXT_BITS));
    prep(priv_pkg::MODE_U, NOP);
    r_ms_rd = 32'h1 << `MSTATUS_MPRV_POS;
    retire("csr_mprv_u", bit_for(check_pkg::CHK_UMODE_MPRV));
  endtask

  task automatic test_wfi_ecall();
    prep(priv_pkg::MODE_U, `INSN_WFI);
    r_ms_rd = 32'h1 << `MSTATUS_TW_POS;
    with_trap(`CAUSE_ILLEGAL);
    retire("wfi_tw_illegal", '0);
    handle_trap("wfi_tw_illegal");
    prep(priv_pkg::MODE_U, `INSN_WFI);
    r_ms_rd = 32'h1 << `MSTATUS_TW_POS;
    retire("wfi_tw_no_trap", bit_for(check_pkg::CHK_WFI));
    prep(priv_pkg::MODE_U, `INSN_WFI);
    with_trap(`CAUSE_ILLEGAL);
    retire("wfi_no_tw_illegal", bit_for(check_pkg::CHK_WFI));
    handle_trap("wfi_no_tw_illegal");
    prep(priv_pkg::MODE_U, `INSN_ECALL);
    with_trap(`CAUSE_ECALL_U);
    retire("ecall_u_cause8", '0);
    handle_trap("ecall_u_cause8");
    prep(priv_pkg::MODE_U, `INSN_ECALL);
    with_trap(6'd5);
    retire("ecall_u_cause5", bit_for(check_pkg::CHK_ECALL));
    handle_trap("ecall_u_cause5");
    // illegal instruction does not outrank the ecall
    prep(priv_pkg::MODE_U, `INSN_ECALL);
    with_trap(`CAUSE_ILLEGAL);
    retire("ecall_u_cause2", bit_for(check_pkg::CHK_ECALL));
    handle_trap("ecall_u_cause2");
  endtask

  task automatic test_illegal_insn();
    prep(priv_pkg::MODE_U, `INSN_URET);
    retire("uret_no_trap", bit_for(check_pkg::CHK_ILLEGAL_INSN));
    prep(priv_pkg::MODE_U, `INSN_URET);
    with_trap(`CAUSE_HIPRI_B);
    retire("uret_cause24", '0);
    handle_trap("uret_cause24");
    prep(priv_pkg::MODE_U, CSRRS_MSTATUS);
    with_trap(`CAUSE_ILLEGAL);
    retire("csr_u_illegal", '0);
    handle_trap("csr_u_illegal");
    prep(priv_pkg::MODE_U, CSRRS_MSTATUS);
    retire("csr_u_no_trap", bit_for(check_pkg::CHK_ILLEGAL_INSN));
    prep(priv_pkg::MODE_U, `INSN_CUSTOM0);
    with_trap(`CAUSE_HIPRI_C);
    retire("custom_cause25", '0);
    handle_trap("custom_cause25");
    prep(priv_pkg::MODE_U, `INSN_CUSTOM0);
    retire("custom_no_trap", bit_for(check_pkg::CHK_ILLEGAL_INSN));
    prep(priv_pkg::MODE_U, `INSN_MRET);
    with_trap(`CAUSE_ILLEGAL);
    retire("mret_u_illegal", '0);
    handle_trap("mret_u_illegal");
    prep(priv_pkg::MODE_U, `INSN_MRET);
    retire("mret_u_no_trap", bit_for(check_pkg::CHK_ILLEGAL_INSN));
  endtask

  // gap idle cycles between each pair of related retirements
  task automatic test_mode_flow(input int gap);
    prep(priv_pkg::MODE_M, NOP);
    with_trap(`CAUSE_HIPRI_A);
    retire("flow_trap", '0);
    idle(gap);
    prep(priv_pkg::MODE_U, NOP);
    retire("flow_trap_then_u", bit_for(check_pkg::CHK_TRAP_TO_M));
    prep(priv_pkg::MODE_M, `INSN_MRET);
    retire("flow_mret_mpp_u", '0);
    idle(gap);
    prep(priv_pkg::MODE_M, NOP);
    retire("flow_mret_then_m", bit_for(check_pkg::CHK_MRET_MPP));
    prep(priv_pkg::MODE_M, `INSN_MRET);
    r_ms_rd = 32'h1 << `MSTATUS_MPRV_POS;
    retire("flow_mret_keeps_mprv", bit_for(check_pkg::CHK_MRET_MPRV));
    idle(gap);
    prep(priv_pkg::MODE_U, NOP);
    retire("flow_mret_lands_u", '0);
  endtask

  initial begin
    int waited;
    rvfi_valid    <= 1'b0;
    rvfi_mode     <= priv_pkg::MODE_M;
    rvfi_insn     <= NOP;
    trap          <= 1'b0;
    exc_cause     <= '0;
    illegal       <= 1'b0;
    mstatus_rdata <= '0;
    mstatus_wdata <= '0;
    mstatus_wmask <= '0;
    misa_rdata    <= MISA_OK;
    sticky_exp    = '0;
    waited        = 0;
    while (arst_n !== 1'b1) begin
      if (waited == RESET_TIMEOUT) begin
        $display("reset was not released within %0d cycles", waited);
        stop_failed();
      end
      @(negedge clk_i);
      waited++;
    end
    test_reset_and_legal();
    test_csr_state();
    test_wfi_ecall();
    test_illegal_insn();
    test_mode_flow(0);
    test_mode_flow(5);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
hdl/priv_pkg.sv
hdl/check_pkg.sv
hdl/retire_decoder.sv
hdl/csr_state_checks.sv
hdl/insn_legality_checks.sv
hdl/mode_flow_checks.sv
hdl/umode_monitor.sv
bench/tb_clock.sv
bench/umode_monitor_props.sv
bench/umode_monitor_tb.sv

//--- Makefile
# Verilator build and run of the user-mode privilege monitor testbench.
# A failing run ends in $fatal, so the run target fails with it.

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := umode_monitor_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
